// ==== verilog/cache_dma_pkg.sv ====
// cache dma package with the command and sequencer state types and default widths
package cache_dma_pkg;

  // default sizes of the data cache and memory bus
  localparam int addr_width_c          = 32;
  localparam int data_width_c          = 32;
  localparam int dma_data_width_c      = 64;
  localparam int block_size_in_words_c = 4;
  localparam int sets_c                = 16;
  localparam int ways_c                = 2;

  // commands from the miss sequencer to the dma engine
  typedef enum logic [2:0] {
    e_dma_nop,
    e_dma_send_fill_addr,
    e_dma_send_evict_addr,
    e_dma_get_fill_data,
    e_dma_send_evict_data
  } dma_cmd_e;

  // miss sequencer states
  typedef enum logic [2:0] {
    S_IDLE,
    S_EVICT_ADDR,
    S_EVICT_DATA,
    S_FILL_ADDR,
    S_FILL_DATA,
    S_DONE
  } miss_state_e;

endpackage

// ==== verilog/dma_fifo.sv ====
// dma fifo, small circular buffer with valid/ready input and valid/yumi output
`timescale 1ns/1ps

module dma_fifo #(
  parameter int width_p,
  parameter int els_p,
  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,

  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  logic [width_p-1:0] mem_r [els_p];

  logic [ptr_width_lp-1:0] rptr_r;
  logic [ptr_width_lp-1:0] wptr_r;
  logic [ptr_width_lp-1:0] rptr_next;
  logic [ptr_width_lp-1:0] wptr_next;
  logic full_r;
  logic full_n;
  logic ready_r;
  logic empty;
  logic push;
  logic pop;

  assign empty = (rptr_r == wptr_r) & ~full_r;
  assign v_o = ~empty;
  assign data_o = mem_r[rptr_r];

  // a full buffer still takes a beat when the head leaves this cycle
  assign ready_o = ready_r | (full_r & yumi_i);
  assign push = v_i & ready_o;
  assign pop = yumi_i;

  assign rptr_next = (rptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
  assign wptr_next = (wptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;

  always_comb begin
    if (push & ~pop) begin
      full_n = (wptr_next == rptr_r);
    end else if (pop & ~push) begin
      full_n = 1'b0;
    end else begin
      full_n = full_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r  <= '0;
      wptr_r  <= '0;
      full_r  <= 1'b0;
      ready_r <= 1'b0;
    end else begin
      if (push) begin
        wptr_r <= wptr_next;
      end
      if (pop) begin
        rptr_r <= rptr_next;
      end
      full_r  <= full_n;
      ready_r <= ~full_n;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

// ==== verilog/cache_data_mem.sv ====
// cache data memory, one beat-wide array per way with byte writes and registered read
`timescale 1ns/1ps

module cache_data_mem #(
  parameter int data_width_p,
  parameter int dma_data_width_p,
  parameter int block_size_in_words_p,
  parameter int sets_p,
  parameter int ways_p,
  localparam int burst_len_lp = block_size_in_words_p * data_width_p / dma_data_width_p,
  localparam int els_lp = sets_p * burst_len_lp,
  localparam int addr_width_lp = $clog2(els_lp),
  localparam int mask_width_lp = dma_data_width_p / 8
) (
  input  logic                                          clk_i,
  input  logic                                          v_i,
  input  logic                                          w_i,
  input  logic [addr_width_lp-1:0]                      addr_i,
  input  logic [ways_p-1:0][mask_width_lp-1:0]          w_mask_i,
  input  logic [ways_p-1:0][dma_data_width_p-1:0]       data_i,
  output logic [ways_p-1:0][dma_data_width_p-1:0]       data_o
);

  genvar way;

  for (way = 0; way < ways_p; way++) begin : g_way
    logic [dma_data_width_p-1:0] mem_r [els_lp];

    // byte enabled write
    always_ff @(posedge clk_i) begin
      if (v_i & w_i) begin
        for (int b = 0; b < mask_width_lp; b++) begin
          if (w_mask_i[way][b]) begin
            mem_r[addr_i][b*8 +: 8] <= data_i[way][b*8 +: 8];
          end
        end
      end
    end

    // read data holds until the next read
    always_ff @(posedge clk_i) begin
      if (v_i & ~w_i) begin
        data_o[way] <= mem_r[addr_i];
      end
    end
  end

endmodule

// ==== verilog/cache_dma.sv ====
// cache dma engine, moves blocks between the memory bus and the data memory
`timescale 1ns/1ps

module cache_dma
  import cache_dma_pkg::*;
#(
  parameter int addr_width_p,
  parameter int data_width_p,
  parameter int dma_data_width_p,
  parameter int block_size_in_words_p,
  parameter int sets_p,
  parameter int ways_p,
  localparam int lg_ways_lp = $clog2(ways_p),
  localparam int lg_sets_lp = $clog2(sets_p),
  localparam int burst_len_lp = block_size_in_words_p * data_width_p / dma_data_width_p,
  localparam int lg_burst_len_lp = $clog2(burst_len_lp),
  localparam int words_per_beat_lp = dma_data_width_p / data_width_p,
  localparam int lg_words_per_beat_lp = $clog2(words_per_beat_lp),
  localparam int mem_addr_width_lp = lg_sets_lp + lg_burst_len_lp,
  localparam int mask_width_lp = dma_data_width_p / 8
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  dma_cmd_e                                dma_cmd_i,
  input  logic [lg_ways_lp-1:0]                   dma_way_i,
  input  logic [addr_width_p-1:0]                 dma_addr_i,
  output logic                                    done_o,
  output logic [data_width_p-1:0]                 snoop_word_o,

  output logic                                    dma_pkt_v_o,
  output logic                                    dma_pkt_write_o,
  output logic [addr_width_p-1:0]                 dma_pkt_addr_o,
  input  logic                                    dma_pkt_yumi_i,

  input  logic [dma_data_width_p-1:0]             dma_data_i,
  input  logic                                    dma_data_v_i,
  output logic                                    dma_data_ready_o,

  output logic [dma_data_width_p-1:0]             dma_data_o,
  output logic                                    dma_data_v_o,
  input  logic                                    dma_data_yumi_i,

  output logic                                    mem_v_o,
  output logic                                    mem_w_o,
  output logic [mem_addr_width_lp-1:0]            mem_addr_o,
  output logic [ways_p-1:0][mask_width_lp-1:0]    mem_w_mask_o,
  output logic [ways_p-1:0][dma_data_width_p-1:0] mem_data_o,
  input  logic [ways_p-1:0][dma_data_width_p-1:0] mem_data_i
);

  localparam int byte_off_width_lp = $clog2(data_width_p / 8);
  localparam int block_off_width_lp = byte_off_width_lp + $clog2(block_size_in_words_p);
  localparam int counter_width_lp = $clog2(burst_len_lp + 1);

  typedef enum logic [1:0] {
    IDLE,
    GET_FILL_DATA,
    SEND_EVICT_DATA
  } dma_state_e;

  dma_state_e state_r;
  dma_state_e state_n;

  logic [counter_width_lp-1:0] counter_r;
  logic counter_clear;
  logic counter_up;
  logic counter_fill_max;
  logic counter_evict_max;

  logic in_fifo_v;
  logic [dma_data_width_p-1:0] in_fifo_data;
  logic in_fifo_yumi;

  logic out_fifo_v;
  logic out_fifo_ready;
  logic [dma_data_width_p-1:0] out_fifo_data;

  logic snoop_we;
  logic [lg_words_per_beat_lp-1:0] snoop_word_off;
  logic [lg_burst_len_lp-1:0] snoop_beat_idx;

  assign counter_fill_max = (counter_r == counter_width_lp'(burst_len_lp - 1));
  assign counter_evict_max = (counter_r == counter_width_lp'(burst_len_lp));

  // beats from the bus, waiting to be written into the data memory
  dma_fifo #(
    .width_p(dma_data_width_p),
    .els_p  (2)
  ) in_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (dma_data_v_i),
    .data_i (dma_data_i),
    .ready_o(dma_data_ready_o),
    .v_o    (in_fifo_v),
    .data_o (in_fifo_data),
    .yumi_i (in_fifo_yumi)
  );

  // evicted beats on their way to the bus
  dma_fifo #(
    .width_p(dma_data_width_p),
    .els_p  (2)
  ) out_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (out_fifo_v),
    .data_i (out_fifo_data),
    .ready_o(out_fifo_ready),
    .v_o    (dma_data_v_o),
    .data_o (dma_data_o),
    .yumi_i (dma_data_yumi_i)
  );

  // block aligned packet address
  assign dma_pkt_addr_o = {dma_addr_i[addr_width_p-1:block_off_width_lp],
                           {block_off_width_lp{1'b0}}};

  assign mem_addr_o = {dma_addr_i[block_off_width_lp +: lg_sets_lp],
                       counter_r[lg_burst_len_lp-1:0]};

  // fill beat goes to every way, the mask picks the victim way
  assign mem_data_o = {ways_p{in_fifo_data}};

  genvar way;
  for (way = 0; way < ways_p; way++) begin : g_mask
    assign mem_w_mask_o[way] = {mask_width_lp{dma_way_i == lg_ways_lp'(way)}};
  end

  assign out_fifo_data = mem_data_i[dma_way_i];

  always_comb begin
    state_n = state_r;
    done_o = 1'b0;
    dma_pkt_v_o = 1'b0;
    dma_pkt_write_o = 1'b0;
    mem_v_o = 1'b0;
    mem_w_o = 1'b0;
    in_fifo_yumi = 1'b0;
    out_fifo_v = 1'b0;
    counter_clear = 1'b0;
    counter_up = 1'b0;

    case (state_r)
      IDLE: begin
        case (dma_cmd_i)
          e_dma_send_fill_addr: begin
            dma_pkt_v_o = 1'b1;
            done_o = dma_pkt_yumi_i;
          end
          e_dma_send_evict_addr: begin
            dma_pkt_v_o = 1'b1;
            dma_pkt_write_o = 1'b1;
            done_o = dma_pkt_yumi_i;
          end
          e_dma_get_fill_data: begin
            counter_clear = 1'b1;
            state_n = GET_FILL_DATA;
          end
          e_dma_send_evict_data: begin
            // beat 0 is read on the way out of idle
            counter_clear = 1'b1;
            counter_up = 1'b1;
            mem_v_o = 1'b1;
            state_n = SEND_EVICT_DATA;
          end
          default: begin
            state_n = IDLE;
          end
        endcase
      end

      GET_FILL_DATA: begin
        mem_v_o = in_fifo_v;
        mem_w_o = in_fifo_v;
        in_fifo_yumi = in_fifo_v;
        counter_up = in_fifo_v & ~counter_fill_max;
        counter_clear = in_fifo_v & counter_fill_max;
        done_o = in_fifo_v & counter_fill_max;
        if (in_fifo_v & counter_fill_max) begin
          state_n = IDLE;
        end
      end

      SEND_EVICT_DATA: begin
        // push the previous read, then read the next beat
        out_fifo_v = 1'b1;
        mem_v_o = out_fifo_ready & ~counter_evict_max;
        counter_up = out_fifo_ready & ~counter_evict_max;
        counter_clear = out_fifo_ready & counter_evict_max;
        done_o = out_fifo_ready & counter_evict_max;
        if (out_fifo_ready & counter_evict_max) begin
          state_n = IDLE;
        end
      end

      default: begin
        state_n = IDLE;
      end
    endcase
  end

  // requested word, caught as the fill beats go by
  assign snoop_word_off = dma_addr_i[byte_off_width_lp +: lg_words_per_beat_lp];
  assign snoop_beat_idx = dma_addr_i[byte_off_width_lp + lg_words_per_beat_lp +: lg_burst_len_lp];
  assign snoop_we = (state_r == GET_FILL_DATA) & in_fifo_v
                  & (counter_r[lg_burst_len_lp-1:0] == snoop_beat_idx);

  always_ff @(posedge clk_i) begin
    if (snoop_we) begin
      snoop_word_o <= in_fifo_data[snoop_word_off*data_width_p +: data_width_p];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      counter_r <= '0;
    end else begin
      state_r <= state_n;
      if (counter_clear) begin
        counter_r <= counter_up ? counter_width_lp'(1) : '0;
      end else if (counter_up) begin
        counter_r <= counter_r + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/cache_miss_seq.sv ====
// cache miss sequencer, orders the evict and fill dma commands for one miss
`timescale 1ns/1ps

module cache_miss_seq
  import cache_dma_pkg::*;
#(
  parameter int addr_width_p,
  parameter int ways_p,
  localparam int lg_ways_lp = $clog2(ways_p)
) (
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  logic                    miss_v_i,
  input  logic [addr_width_p-1:0] miss_addr_i,
  input  logic [lg_ways_lp-1:0]   miss_way_i,
  input  logic                    miss_dirty_i,
  input  logic [addr_width_p-1:0] evict_addr_i,

  input  logic                    dma_done_i,
  output dma_cmd_e                dma_cmd_o,
  output logic [lg_ways_lp-1:0]   dma_way_o,
  output logic [addr_width_p-1:0] dma_addr_o,
  output logic                    miss_done_o
);

  miss_state_e state_r;
  miss_state_e state_n;

  // requester holds its inputs until done, so the command fields stay stable
  assign dma_way_o = miss_way_i;
  assign dma_addr_o = ((state_r == S_EVICT_ADDR) || (state_r == S_EVICT_DATA))
                    ? evict_addr_i : miss_addr_i;
  assign miss_done_o = (state_r == S_DONE);

  always_comb begin
    state_n = state_r;
    dma_cmd_o = e_dma_nop;

    case (state_r)
      S_IDLE: begin
        if (miss_v_i) begin
          // a clean victim goes straight to the fill
          state_n = miss_dirty_i ? S_EVICT_ADDR : S_FILL_ADDR;
        end
      end
      S_EVICT_ADDR: begin
        dma_cmd_o = e_dma_send_evict_addr;
        if (dma_done_i) begin
          state_n = S_EVICT_DATA;
        end
      end
      S_EVICT_DATA: begin
        dma_cmd_o = e_dma_send_evict_data;
        if (dma_done_i) begin
          state_n = S_FILL_ADDR;
        end
      end
      S_FILL_ADDR: begin
        dma_cmd_o = e_dma_send_fill_addr;
        if (dma_done_i) begin
          state_n = S_FILL_DATA;
        end
      end
      S_FILL_DATA: begin
        dma_cmd_o = e_dma_get_fill_data;
        if (dma_done_i) begin
          state_n = S_DONE;
        end
      end
      S_DONE: begin
        state_n = S_IDLE;
      end
      default: begin
        state_n = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= S_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

// ==== verilog/cache_dma_top.sv ====
// cache dma top level, joins the miss sequencer, dma engine and data memory
`timescale 1ns/1ps

module cache_dma_top
  import cache_dma_pkg::*;
#(
  parameter int addr_width_p          = addr_width_c,
  parameter int data_width_p          = data_width_c,
  parameter int dma_data_width_p      = dma_data_width_c,
  parameter int block_size_in_words_p = block_size_in_words_c,
  parameter int sets_p                = sets_c,
  parameter int ways_p                = ways_c,
  localparam int lg_ways_lp = $clog2(ways_p),
  localparam int burst_len_lp = block_size_in_words_p * data_width_p / dma_data_width_p,
  localparam int mem_addr_width_lp = $clog2(sets_p) + $clog2(burst_len_lp),
  localparam int mask_width_lp = dma_data_width_p / 8
) (
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic                        miss_v_i,
  input  logic [addr_width_p-1:0]     miss_addr_i,
  input  logic [lg_ways_lp-1:0]       miss_way_i,
  input  logic                        miss_dirty_i,
  input  logic [addr_width_p-1:0]     evict_addr_i,
  output logic                        miss_done_o,
  output logic [data_width_p-1:0]     snoop_word_o,

  output logic                        dma_pkt_v_o,
  output logic                        dma_pkt_write_o,
  output logic [addr_width_p-1:0]     dma_pkt_addr_o,
  input  logic                        dma_pkt_yumi_i,

  input  logic [dma_data_width_p-1:0] dma_data_i,
  input  logic                        dma_data_v_i,
  output logic                        dma_data_ready_o,

  output logic [dma_data_width_p-1:0] dma_data_o,
  output logic                        dma_data_v_o,
  input  logic                        dma_data_yumi_i
);

  dma_cmd_e                dma_cmd;
  logic [lg_ways_lp-1:0]   dma_way;
  logic [addr_width_p-1:0] dma_addr;
  logic                    dma_done;

  logic                                    mem_v;
  logic                                    mem_w;
  logic [mem_addr_width_lp-1:0]            mem_addr;
  logic [ways_p-1:0][mask_width_lp-1:0]    mem_w_mask;
  logic [ways_p-1:0][dma_data_width_p-1:0] mem_wdata;
  logic [ways_p-1:0][dma_data_width_p-1:0] mem_rdata;

  cache_miss_seq #(
    .addr_width_p(addr_width_p),
    .ways_p      (ways_p)
  ) miss_seq (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .miss_v_i    (miss_v_i),
    .miss_addr_i (miss_addr_i),
    .miss_way_i  (miss_way_i),
    .miss_dirty_i(miss_dirty_i),
    .evict_addr_i(evict_addr_i),
    .dma_done_i  (dma_done),
    .dma_cmd_o   (dma_cmd),
    .dma_way_o   (dma_way),
    .dma_addr_o  (dma_addr),
    .miss_done_o (miss_done_o)
  );

  cache_dma #(
    .addr_width_p         (addr_width_p),
    .data_width_p         (data_width_p),
    .dma_data_width_p     (dma_data_width_p),
    .block_size_in_words_p(block_size_in_words_p),
    .sets_p               (sets_p),
    .ways_p               (ways_p)
  ) dma_engine (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .dma_cmd_i       (dma_cmd),
    .dma_way_i       (dma_way),
    .dma_addr_i      (dma_addr),
    .done_o          (dma_done),
    .snoop_word_o    (snoop_word_o),
    .dma_pkt_v_o     (dma_pkt_v_o),
    .dma_pkt_write_o (dma_pkt_write_o),
    .dma_pkt_addr_o  (dma_pkt_addr_o),
    .dma_pkt_yumi_i  (dma_pkt_yumi_i),
    .dma_data_i      (dma_data_i),
    .dma_data_v_i    (dma_data_v_i),
    .dma_data_ready_o(dma_data_ready_o),
    .dma_data_o      (dma_data_o),
    .dma_data_v_o    (dma_data_v_o),
    .dma_data_yumi_i (dma_data_yumi_i),
    .mem_v_o         (mem_v),
    .mem_w_o         (mem_w),
    .mem_addr_o      (mem_addr),
    .mem_w_mask_o    (mem_w_mask),
    .mem_data_o      (mem_wdata),
    .mem_data_i      (mem_rdata)
  );

  cache_data_mem #(
    .data_width_p         (data_width_p),
    .dma_data_width_p     (dma_data_width_p),
    .block_size_in_words_p(block_size_in_words_p),
    .sets_p               (sets_p),
    .ways_p               (ways_p)
  ) data_mem (
    .clk_i   (clk_i),
    .v_i     (mem_v),
    .w_i     (mem_w),
    .addr_i  (mem_addr),
    .w_mask_i(mem_w_mask),
    .data_i  (mem_wdata),
    .data_o  (mem_rdata)
  );

endmodule

// ==== verification/cache_dma_properties.sv ====
// cache dma properties, bus handshake and miss done rules checked on the top level
`timescale 1ns/1ps

module cache_dma_properties #(
  parameter int addr_width_p,
  parameter int dma_data_width_p
) (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        miss_done_i,
  input logic                        pkt_v_i,
  input logic                        pkt_write_i,
  input logic [addr_width_p-1:0]     pkt_addr_i,
  input logic                        pkt_yumi_i,
  input logic [dma_data_width_p-1:0] evict_data_i,
  input logic                        evict_v_i,
  input logic                        evict_yumi_i
);

  int fail_count_r = 0;

  // done is a single cycle pulse
  done_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_done_i |=> !miss_done_i)
    else begin
      $error("miss_done_o held high for more than one cycle");
      fail_count_r++;
    end

  // packet fields hold until the bus takes them
  pkt_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_v_i && !pkt_yumi_i |=> pkt_v_i && $stable(pkt_write_i) && $stable(pkt_addr_i))
    else begin
      $error("packet changed or dropped before yumi");
      fail_count_r++;
    end

  // outgoing beat holds until yumi
  evict_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    evict_v_i && !evict_yumi_i |=> evict_v_i && $stable(evict_data_i))
    else begin
      $error("outgoing beat changed or dropped before yumi");
      fail_count_r++;
    end

endmodule

// ==== verification/cache_dma_checker.sv ====
// cache dma checker, keeps a shadow of the data memory and checks packets, beats and snoop words
`timescale 1ns/1ps

module cache_dma_checker
  import cache_dma_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        miss_v_i,
  input  logic [31:0] miss_addr_i,
  input  logic        miss_way_i,
  input  logic        miss_dirty_i,
  input  logic [31:0] evict_addr_i,
  input  logic        done_i,
  input  logic [31:0] snoop_word_i,
  input  logic        pkt_v_i,
  input  logic        pkt_write_i,
  input  logic [31:0] pkt_addr_i,
  input  logic        pkt_yumi_i,
  input  logic [63:0] fill_data_i,
  input  logic        fill_v_i,
  input  logic        fill_ready_i,
  input  logic [63:0] evict_data_i,
  input  logic        evict_v_i,
  input  logic        evict_yumi_i,
  output int          error_count_o,
  output int          evict_pending_o
);

  localparam int beats_lp = block_size_in_words_c * data_width_c / dma_data_width_c;

  // shadow of the data memory, indexed by set, way and beat
  logic [63:0] shadow_r [sets_c][ways_c][beats_lp];
  logic        shadow_v_r [sets_c][ways_c];
  logic [63:0] evict_q [$];

  logic        busy_r;
  logic        started_r;
  logic        snoop_pending_r;
  logic [31:0] snoop_exp_r;
  logic [31:0] addr_r;
  logic [31:0] evict_addr_r;
  logic        way_r;
  logic        dirty_r;
  int          reads_r;
  int          writes_r;
  int          fills_r;

  task automatic flag_error(input string msg);
    error_count_o++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  initial begin
    error_count_o = 0;
    evict_pending_o = 0;
    foreach (shadow_v_r[s, w]) begin
      shadow_v_r[s][w] = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      busy_r = 1'b0;
      started_r = 1'b0;
      snoop_pending_r = 1'b0;
    end else begin
      if (snoop_pending_r && snoop_word_i !== snoop_exp_r) begin
        flag_error($sformatf("snoop word %h, expected %h for address %h",
                             snoop_word_i, snoop_exp_r, addr_r));
      end
      snoop_pending_r = 1'b0;

      if (!started_r && (pkt_v_i || evict_v_i)) begin
        flag_error("bus valid raised before the first miss");
      end

      if (miss_v_i && !busy_r && !done_i) begin
        if (evict_q.size() != 0) begin
          flag_error("new miss while evicted beats are still missing");
        end
        busy_r = 1'b1;
        started_r = 1'b1;
        addr_r = miss_addr_i;
        evict_addr_r = evict_addr_i;
        way_r = miss_way_i;
        dirty_r = miss_dirty_i;
        reads_r = 0;
        writes_r = 0;
        fills_r = 0;
      end

      if (pkt_v_i && pkt_yumi_i) begin
        if (!busy_r) begin
          flag_error("packet sent outside a miss");
        end else if (pkt_write_i) begin
          if (!dirty_r || writes_r != 0 || reads_r != 0) begin
            flag_error("write packet not expected here");
          end
          if (pkt_addr_i !== {evict_addr_r[31:4], 4'h0}) begin
            flag_error($sformatf("write packet address %h, expected %h",
                                 pkt_addr_i, {evict_addr_r[31:4], 4'h0}));
          end
          if (!shadow_v_r[evict_addr_r[7:4]][way_r]) begin
            flag_error("eviction of a block that was never filled");
          end else begin
            for (int b = 0; b < beats_lp; b++) begin
              evict_q.push_back(shadow_r[evict_addr_r[7:4]][way_r][b]);
            end
          end
          writes_r++;
        end else begin
          if (reads_r != 0 || (dirty_r && writes_r == 0)) begin
            flag_error("read packet repeated or ahead of the write packet");
          end
          if (pkt_addr_i !== {addr_r[31:4], 4'h0}) begin
            flag_error($sformatf("read packet address %h, expected %h",
                                 pkt_addr_i, {addr_r[31:4], 4'h0}));
          end
          reads_r++;
        end
      end

      if (fill_v_i && fill_ready_i) begin
        if (!busy_r || reads_r == 0 || fills_r >= beats_lp) begin
          flag_error("fill beat accepted without a matching read packet");
        end else begin
          shadow_r[addr_r[7:4]][way_r][fills_r] = fill_data_i;
          // requested word sits at beat addr[3], half addr[2]
          if (fills_r == int'(addr_r[3])) begin
            snoop_exp_r = addr_r[2] ? fill_data_i[63:32] : fill_data_i[31:0];
          end
          fills_r++;
        end
      end

      if (evict_v_i && evict_yumi_i) begin
        if (evict_q.size() == 0) begin
          flag_error("evicted beat taken with none outstanding");
        end else if (evict_data_i !== evict_q[0]) begin
          flag_error($sformatf("evicted beat %h, expected %h", evict_data_i, evict_q[0]));
          void'(evict_q.pop_front());
        end else begin
          void'(evict_q.pop_front());
        end
      end

      if (done_i) begin
        if (!busy_r) begin
          flag_error("miss_done_o without a miss");
        end else if (reads_r != 1 || writes_r != int'(dirty_r) || fills_r != beats_lp) begin
          flag_error($sformatf("miss ended with %0d reads, %0d writes, %0d fill beats",
                               reads_r, writes_r, fills_r));
        end
        shadow_v_r[addr_r[7:4]][way_r] = 1'b1;
        snoop_pending_r = busy_r;
        busy_r = 1'b0;
      end
    end
    evict_pending_o = evict_q.size();
  end

endmodule

// ==== verification/cache_dma_tb.sv ====
// cache dma testbench, random misses against a main memory responder on the dma bus
`timescale 1ns/1ps

module cache_dma_tb;

  localparam int miss_count_c = 300;
  localparam int wait_limit_c = 200;

  logic        clk_i;
  logic        reset_i;
  logic        miss_v_i;
  logic [31:0] miss_addr_i;
  logic        miss_way_i;
  logic        miss_dirty_i;
  logic [31:0] evict_addr_i;
  logic        miss_done_o;
  logic [31:0] snoop_word_o;
  logic        dma_pkt_v_o;
  logic        dma_pkt_write_o;
  logic [31:0] dma_pkt_addr_o;
  logic        dma_pkt_yumi_i;
  logic [63:0] dma_data_i;
  logic        dma_data_v_i;
  logic        dma_data_ready_o;
  logic [63:0] dma_data_o;
  logic        dma_data_v_o;
  logic        dma_data_yumi_i;

  int check_errors;
  int evict_pending;
  logic timed_out = 1'b0;

  logic [31:0] lfsr_r = 32'h061c03c2;

  // requester view of the tags held in each set and way
  logic [2:0] tag_r [16][2];
  logic       valid_r [16][2];

  // sparse main memory, one entry per 8 byte beat
  logic [63:0] main_mem [logic [31:0]];
  logic [63:0] fill_q [$];
  logic [31:0] write_addr_r;
  int          write_beat_r;

  cache_dma_top UUT (.*);

  cache_dma_checker check_unit (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .miss_v_i       (miss_v_i),
    .miss_addr_i    (miss_addr_i),
    .miss_way_i     (miss_way_i),
    .miss_dirty_i   (miss_dirty_i),
    .evict_addr_i   (evict_addr_i),
    .done_i         (miss_done_o),
    .snoop_word_i   (snoop_word_o),
    .pkt_v_i        (dma_pkt_v_o),
    .pkt_write_i    (dma_pkt_write_o),
    .pkt_addr_i     (dma_pkt_addr_o),
    .pkt_yumi_i     (dma_pkt_yumi_i),
    .fill_data_i    (dma_data_i),
    .fill_v_i       (dma_data_v_i),
    .fill_ready_i   (dma_data_ready_o),
    .evict_data_i   (dma_data_o),
    .evict_v_i      (dma_data_v_o),
    .evict_yumi_i   (dma_data_yumi_i),
    .error_count_o  (check_errors),
    .evict_pending_o(evict_pending)
  );

  bind cache_dma_top cache_dma_properties #(
    .addr_width_p    (addr_width_p),
    .dma_data_width_p(dma_data_width_p)
  ) props (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .miss_done_i (miss_done_o),
    .pkt_v_i     (dma_pkt_v_o),
    .pkt_write_i (dma_pkt_write_o),
    .pkt_addr_i  (dma_pkt_addr_o),
    .pkt_yumi_i  (dma_pkt_yumi_i),
    .evict_data_i(dma_data_o),
    .evict_v_i   (dma_data_v_o),
    .evict_yumi_i(dma_data_yumi_i)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_r[0]};
      lfsr_r = lfsr_r[0] ? ((lfsr_r >> 1) ^ 32'hA300_0000) : (lfsr_r >> 1);
    end
    return bits;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // bus side: takes packets, returns fill beats and stores evicted beats
  initial begin : responder
    logic        in_reset;
    logic        read_pending;
    logic [31:0] read_addr;
    logic [31:0] beat_addr;
    read_pending = 1'b0;
    read_addr = '0;
    forever begin
      @(posedge clk_i);
      in_reset = reset_i;
      if (dma_pkt_v_o && dma_pkt_yumi_i) begin
        if (dma_pkt_write_o) begin
          write_addr_r = dma_pkt_addr_o;
          write_beat_r = 0;
        end else begin
          read_pending = 1'b1;
          read_addr = dma_pkt_addr_o;
        end
      end
      if (dma_data_v_i && dma_data_ready_o) begin
        void'(fill_q.pop_front());
      end
      if (dma_data_v_o && dma_data_yumi_i) begin
        main_mem[write_addr_r + 32'(8 * write_beat_r)] = dma_data_o;
        write_beat_r++;
      end
      #2;
      if (read_pending) begin
        for (int b = 0; b < 2; b++) begin
          beat_addr = read_addr + 32'(8 * b);
          if (!main_mem.exists(beat_addr)) begin
            main_mem[beat_addr] = {take_bits(32), take_bits(32)};
          end
          fill_q.push_back(main_mem[beat_addr]);
        end
        read_pending = 1'b0;
      end
      if (in_reset) begin
        dma_pkt_yumi_i = 1'b0;
        dma_data_v_i = 1'b0;
        dma_data_yumi_i = 1'b0;
      end else begin
        dma_pkt_yumi_i = dma_pkt_v_o & take_bits(1);
        dma_data_yumi_i = dma_data_v_o & take_bits(1);
        dma_data_v_i = (fill_q.size() > 0) && take_bits(1);
        if (dma_data_v_i) begin
          dma_data_i = fill_q[0];
        end
      end
    end
  end

  // wait until the out fifo has emptied onto the bus
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (dma_data_v_o) begin
      if (waited == wait_limit_c) begin
        $display("timeout waiting for evicted beats to leave the DUT");
        timed_out = 1'b1;
        return;
      end
      @(posedge clk_i);
      waited++;
    end
  endtask

  task automatic run_miss();
    logic [3:0] set;
    logic       way;
    logic [1:0] word;
    logic [2:0] tag;
    logic       dirty;
    int         waited;
    @(posedge clk_i);
    wait_drain();
    if (timed_out) begin
      return;
    end
    set = take_bits(4);
    way = take_bits(1);
    word = take_bits(2);
    tag = take_bits(3);
    if (valid_r[set][way] && tag == tag_r[set][way]) begin
      tag = tag + 3'd1;
    end
    // only a block that was filled can be dirty
    dirty = valid_r[set][way] & take_bits(1);
    #2;
    miss_v_i = 1'b1;
    miss_addr_i = {8'h40, 13'h0, tag, set, word, 2'b00};
    miss_way_i = way;
    miss_dirty_i = dirty;
    evict_addr_i = {8'h40, 13'h0, tag_r[set][way], set, 4'h0};
    waited = 0;
    @(posedge clk_i);
    while (!miss_done_o) begin
      if (waited == wait_limit_c) begin
        $display("timeout waiting for miss_done_o on address %h", miss_addr_i);
        timed_out = 1'b1;
        return;
      end
      @(posedge clk_i);
      waited++;
    end
    #2;
    miss_v_i = 1'b0;
    tag_r[set][way] = tag;
    valid_r[set][way] = 1'b1;
  endtask

  initial begin
    int assert_errors;
    reset_i = 1'b1;
    miss_v_i = 1'b0;
    miss_addr_i = '0;
    miss_way_i = 1'b0;
    miss_dirty_i = 1'b0;
    evict_addr_i = '0;
    dma_pkt_yumi_i = 1'b0;
    dma_data_i = '0;
    dma_data_v_i = 1'b0;
    dma_data_yumi_i = 1'b0;
    foreach (valid_r[s, w]) begin
      valid_r[s][w] = 1'b0;
      tag_r[s][w] = '0;
    end
    repeat (4) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    // quiet bus expected until the first miss
    repeat (6) @(posedge clk_i);
    for (int n = 0; n < miss_count_c && !timed_out; n++) begin
      run_miss();
    end
    if (!timed_out) begin
      @(posedge clk_i);
      wait_drain();
    end
    repeat (2) @(posedge clk_i);
    assert_errors = UUT.props.fail_count_r;
    $display("checker errors %0d, assertion errors %0d, beats never evicted %0d",
             check_errors, assert_errors, evict_pending);
    if (!timed_out && check_errors == 0 && assert_errors == 0 && evict_pending == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
verilog/cache_dma_pkg.sv
verilog/dma_fifo.sv
verilog/cache_data_mem.sv
verilog/cache_dma.sv
verilog/cache_miss_seq.sv
verilog/cache_dma_top.sv
verification/cache_dma_properties.sv
verification/cache_dma_checker.sv
verification/cache_dma_tb.sv
